// File: common/lc3b_types.sv
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_not  = 4'b1001, // 4'b1000 (rti) is not decoded
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        lc3b_pc_mux_sel_pc_plus2 = 2'd0,
        lc3b_pc_mux_sel_pcn      = 2'd1, // pc + adder offset
        lc3b_pc_mux_sel_alu      = 2'd2,
        lc3b_pc_mux_sel_mdr      = 2'd3  // trap vector fetch
    } lc3b_pc_mux_sel;

    typedef enum logic [1:0] {
        lc3b_pc_adder_mux_sel_offset9  = 2'd0,
        lc3b_pc_adder_mux_sel_offset11 = 2'd1
    } lc3b_pc_adder_mux_sel;

    typedef enum logic [2:0] {
        lc3b_alu_mux_sel_sr2       = 3'd0,
        lc3b_alu_mux_sel_imm5      = 3'd1,
        lc3b_alu_mux_sel_imm4      = 3'd2,
        lc3b_alu_mux_sel_offset6_b = 3'd3, // byte offset
        lc3b_alu_mux_sel_offset6_w = 3'd4  // word offset, shifted left
    } lc3b_alu_mux_sel;

    typedef enum logic [1:0] {
        lc3b_cc_gen_mux_sel_alu = 2'd0,
        lc3b_cc_gen_mux_sel_pcn = 2'd1,
        lc3b_cc_gen_mux_sel_mdr = 2'd2
    } lc3b_cc_gen_mux_sel;

    typedef enum logic [1:0] {
        lc3b_data_memory_addr_mux_sel_alu       = 2'd0,
        lc3b_data_memory_addr_mux_sel_trapvect8 = 2'd1
    } lc3b_data_memory_addr_mux_sel;

    typedef enum logic [1:0] {
        lc3b_regfile_data_mux_sel_alu = 2'd0,
        lc3b_regfile_data_mux_sel_pcn = 2'd1,
        lc3b_regfile_data_mux_sel_mdr = 2'd2,
        lc3b_regfile_data_mux_sel_pc  = 2'd3  // link value for jsr/trap
    } lc3b_regfile_data_mux_sel;

    typedef enum logic [2:0] {
        lc3b_alu_op_add  = 3'd0,
        lc3b_alu_op_and  = 3'd1,
        lc3b_alu_op_not  = 3'd2,
        lc3b_alu_op_pass = 3'd3,
        lc3b_alu_op_sll  = 3'd4,
        lc3b_alu_op_srl  = 3'd5,
        lc3b_alu_op_sra  = 3'd6
    } lc3b_alu_op;

    typedef struct packed {
        lc3b_pc_mux_sel               pc_mux_sel;
        logic                         requires_sr1;
        logic                         requires_sr2;
        lc3b_reg                      regfile_sr1;
        lc3b_reg                      regfile_sr2;
        lc3b_pc_adder_mux_sel         pc_adder_mux_sel;
        lc3b_alu_mux_sel              alu_mux_sel;
        lc3b_alu_op                   alu_op;
        logic                         cc_load;
        lc3b_cc_gen_mux_sel           cc_gen_mux_sel;
        logic                         br_en_load;
        logic                         data_memory_access;
        logic                         data_memory_write_enable;
        lc3b_data_memory_addr_mux_sel data_memory_addr_mux_sel;
        logic                         data_memory_word_align;
        lc3b_regfile_data_mux_sel     regfile_data_mux_sel;
        lc3b_reg                      regfile_dest;
        logic                         regfile_load;
    } lc3b_control_word;

endpackage : lc3b_types

`default_nettype wire

// File: common/decode_pkg.sv
`default_nettype none

package decode_pkg;

    import lc3b_types::*;

    localparam int IN_DEPTH    = 4; // power of two, pointers wrap
    localparam int OUT_CREDITS = 2;

    localparam int IN_PTR_W  = $clog2(IN_DEPTH);
    localparam int IN_CNT_W  = $clog2(IN_DEPTH + 1);
    localparam int OUT_CNT_W = $clog2(OUT_CREDITS + 1);

    typedef struct packed {
        lc3b_word ir;
        lc3b_word pc;
    } fetch_bundle_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
        lc3b_word         ir;
        lc3b_word         pc;
    } decoded_bundle_t;

endpackage : decode_pkg

`default_nettype wire

// File: common/credit_if.sv
`default_nettype none

// one credit per slot, receiver pulses credit for each slot it frees
interface credit_if #(
    parameter type payload_t = logic
) (
    input logic clk
);

    logic     valid;
    logic     credit;
    payload_t payload;

    modport sender (
        input  clk, credit,
        output valid, payload
    );

    modport receiver (
        input  clk, valid, payload,
        output credit
    );

endinterface : credit_if

`default_nettype wire

// File: decode/control_rom.sv
`default_nettype none

module control_rom
    import lc3b_types::*;
(
    input  lc3b_word         ir_in,
    output lc3b_control_word control_out
);

    lc3b_opcode opcode;
    lc3b_reg    dest;
    lc3b_reg    sr1;
    lc3b_reg    sr2;

    assign opcode = lc3b_opcode'(ir_in[15:12]);
    assign dest   = ir_in[11:9];
    assign sr1    = ir_in[8:6];
    assign sr2    = ir_in[2:0];

    always_comb begin
        control_out = '0; // all selects default to encoding 0
        control_out.pc_mux_sel           = lc3b_pc_mux_sel_pc_plus2;
        control_out.pc_adder_mux_sel     = lc3b_pc_adder_mux_sel_offset9;
        control_out.alu_mux_sel          = lc3b_alu_mux_sel_sr2;
        control_out.alu_op               = lc3b_alu_op_pass;
        control_out.cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_alu;
        control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;

        case (opcode)
            op_add, op_and: begin
                control_out.requires_sr1 = 1'b1;
                control_out.regfile_sr1  = sr1;
                control_out.regfile_sr2  = sr2;
                if (ir_in[5]) begin // immediate form
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_imm5;
                end else begin
                    control_out.requires_sr2 = 1'b1;
                end
                control_out.alu_op = (opcode == op_add) ? lc3b_alu_op_add
                                                        : lc3b_alu_op_and;
                control_out.cc_load      = 1'b1;
                control_out.regfile_dest = dest;
                control_out.regfile_load = 1'b1;
            end
            op_not: begin
                control_out.requires_sr1 = 1'b1;
                control_out.regfile_sr1  = sr1;
                control_out.alu_op       = lc3b_alu_op_not;
                control_out.cc_load      = 1'b1;
                control_out.regfile_dest = dest;
                control_out.regfile_load = 1'b1;
            end
            op_shf: begin
                control_out.requires_sr1 = 1'b1;
                control_out.regfile_sr1  = sr1;
                control_out.alu_mux_sel  = lc3b_alu_mux_sel_imm4;
                if (!ir_in[4]) begin
                    control_out.alu_op = lc3b_alu_op_sll;
                end else if (!ir_in[5]) begin
                    control_out.alu_op = lc3b_alu_op_srl;
                end else begin
                    control_out.alu_op = lc3b_alu_op_sra;
                end
                control_out.cc_load      = 1'b1;
                control_out.regfile_dest = dest;
                control_out.regfile_load = 1'b1;
            end
            op_lea: begin
                control_out.cc_load              = 1'b1;
                control_out.cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_pcn;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_pcn;
                control_out.regfile_dest         = dest;
                control_out.regfile_load         = 1'b1;
            end
            op_ldb, op_ldi, op_ldr: begin
                control_out.requires_sr1 = 1'b1;
                control_out.regfile_sr1  = sr1;
                control_out.alu_op       = lc3b_alu_op_add; // base + offset
                if (opcode == op_ldb) begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_offset6_b;
                end else begin
                    control_out.alu_mux_sel            = lc3b_alu_mux_sel_offset6_w;
                    control_out.data_memory_word_align = 1'b1;
                end
                control_out.cc_load              = 1'b1;
                control_out.cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_mdr;
                control_out.data_memory_access   = 1'b1;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_mdr;
                control_out.regfile_dest         = dest;
                control_out.regfile_load         = 1'b1;
            end
            op_stb, op_sti, op_str: begin
                control_out.requires_sr1 = 1'b1;
                control_out.requires_sr2 = 1'b1;
                control_out.regfile_sr1  = sr1;
                control_out.regfile_sr2  = dest; // store data sits in ir[11:9]
                control_out.alu_op       = lc3b_alu_op_add;
                if (opcode == op_stb) begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_offset6_b;
                end else begin
                    control_out.alu_mux_sel            = lc3b_alu_mux_sel_offset6_w;
                    control_out.data_memory_word_align = 1'b1;
                end
                control_out.data_memory_access       = 1'b1;
                control_out.data_memory_write_enable = 1'b1;
            end
            op_br: begin
                control_out.pc_mux_sel = lc3b_pc_mux_sel_pcn;
                control_out.br_en_load = 1'b1; // taken decided by nzp later
            end
            op_jmp: begin
                control_out.pc_mux_sel   = lc3b_pc_mux_sel_alu;
                control_out.requires_sr1 = 1'b1;
                control_out.regfile_sr1  = sr1;
            end
            op_jsr: begin
                control_out.pc_mux_sel = ir_in[11] ? lc3b_pc_mux_sel_pcn
                                                   : lc3b_pc_mux_sel_alu; // jsrr
                control_out.requires_sr1         = 1'b1;
                control_out.regfile_sr1          = sr1;
                control_out.pc_adder_mux_sel     = lc3b_pc_adder_mux_sel_offset11;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_pc;
                control_out.regfile_dest         = 3'd7;
                control_out.regfile_load         = 1'b1;
            end
            op_trap: begin
                control_out.pc_mux_sel = lc3b_pc_mux_sel_mdr;
                control_out.data_memory_access       = 1'b1;
                control_out.data_memory_addr_mux_sel =
                    lc3b_data_memory_addr_mux_sel_trapvect8;
                control_out.data_memory_word_align   = 1'b1;
                control_out.regfile_data_mux_sel     = lc3b_regfile_data_mux_sel_pc;
                control_out.regfile_dest             = 3'd7;
                control_out.regfile_load             = 1'b1;
            end
            default: begin
                control_out = '0; // unknown opcode
            end
        endcase
    end

endmodule : control_rom

`default_nettype wire

// File: decode/regfile.sv
`default_nettype none

module regfile
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  lc3b_reg  waddr,
    input  lc3b_word wdata,
    input  lc3b_reg  raddr_a,
    input  lc3b_reg  raddr_b,
    output lc3b_word rdata_a,
    output lc3b_word rdata_b
);

    lc3b_word regs [8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // bypass so a reader in the write cycle sees the new value
    assign rdata_a = (we && (raddr_a == waddr)) ? wdata : regs[raddr_a];
    assign rdata_b = (we && (raddr_b == waddr)) ? wdata : regs[raddr_b];

endmodule : regfile

`default_nettype wire

// File: decode/scoreboard.sv
`default_nettype none

module scoreboard
    import lc3b_types::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             set_en,
    input  lc3b_reg          set_reg,
    input  lc3b_reg          clr_reg,
    input  logic             clr_en,
    input  lc3b_control_word ctrl,
    output logic             can_issue
);

    logic [7:0] pending;
    logic [7:0] clr_mask;
    logic [7:0] busy; // pending, minus a register retiring this cycle

    assign clr_mask = {7'b0, clr_en} << clr_reg;
    assign busy     = pending & ~clr_mask;

    assign can_issue = !(ctrl.requires_sr1 && busy[ctrl.regfile_sr1]) &&
                       !(ctrl.requires_sr2 && busy[ctrl.regfile_sr2]) &&
                       !(ctrl.regfile_load && busy[ctrl.regfile_dest]); // waw

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (clr_en) pending[clr_reg] <= 1'b0;
            if (set_en) pending[set_reg] <= 1'b1; // set wins on same reg
        end
    end

    // every writeback must match an earlier issue
    a_clr_pending: assert property (@(posedge clk) disable iff (!rst_n)
        clr_en |-> pending[clr_reg]);

endmodule : scoreboard

`default_nettype wire

// File: decode/decode_stage.sv
`default_nettype none

module decode_stage
    import lc3b_types::*;
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    credit_if.receiver fetch_ch,
    credit_if.sender   dec_ch,
    input  logic     wb_valid,
    input  lc3b_reg  wb_dest,
    input  lc3b_word wb_data
);

    fetch_bundle_t          fifo_q [IN_DEPTH];
    logic [IN_PTR_W-1:0]    wr_ptr;
    logic [IN_PTR_W-1:0]    rd_ptr;
    logic [IN_CNT_W-1:0]    fifo_cnt;
    logic [OUT_CNT_W-1:0]   out_cnt;
    logic [OUT_CNT_W:0]     in_flight; // bundles sent, credit not yet back
    fetch_bundle_t          head;
    lc3b_control_word       ctrl;
    lc3b_word               sr1_data;
    lc3b_word               sr2_data;
    logic                   can_issue;
    logic                   issue;

    assign head  = fifo_q[rd_ptr];
    assign issue = (fifo_cnt != '0) && (out_cnt != '0) && can_issue;

    assign fetch_ch.credit = issue; // slot frees as the head leaves

    control_rom u_rom (.ir_in(head.ir), .control_out(ctrl));

    regfile u_rf (
        .clk, .rst_n,
        .we(wb_valid), .waddr(wb_dest), .wdata(wb_data),
        .raddr_a(ctrl.regfile_sr1), .raddr_b(ctrl.regfile_sr2),
        .rdata_a(sr1_data), .rdata_b(sr2_data)
    );

    scoreboard u_sb (
        .clk, .rst_n,
        .set_en(issue && ctrl.regfile_load), .set_reg(ctrl.regfile_dest),
        .clr_reg(wb_dest), .clr_en(wb_valid),
        .ctrl, .can_issue
    );

    always_ff @(posedge clk) begin
        if (fetch_ch.valid) fifo_q[wr_ptr] <= fetch_ch.payload;
        if (issue) begin
            dec_ch.payload <= '{ctrl: ctrl, sr1_data: sr1_data, sr2_data: sr2_data,
                                ir: head.ir, pc: head.pc};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_cnt     <= '0;
            out_cnt      <= OUT_CNT_W'(OUT_CREDITS);
            in_flight    <= '0;
            dec_ch.valid <= 1'b0;
        end else begin
            if (fetch_ch.valid) wr_ptr <= wr_ptr + 1'b1;
            if (issue) rd_ptr <= rd_ptr + 1'b1;
            fifo_cnt     <= fifo_cnt + IN_CNT_W'(fetch_ch.valid) - IN_CNT_W'(issue);
            out_cnt      <= out_cnt + OUT_CNT_W'(dec_ch.credit) - OUT_CNT_W'(issue);
            in_flight    <= in_flight + {{OUT_CNT_W{1'b0}}, dec_ch.valid}
                                      - {{OUT_CNT_W{1'b0}}, dec_ch.credit};
            dec_ch.valid <= issue;
        end
    end

    // upstream must honour the credits it was given
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ch.valid |-> fifo_cnt < IN_CNT_W'(IN_DEPTH));

    // downstream returns no more credits than it received
    a_out_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= OUT_CNT_W'(OUT_CREDITS));

    // a new bundle needs a free downstream slot
    a_valid_credit: assert property (@(posedge clk) disable iff (!rst_n)
        dec_ch.valid |-> in_flight < OUT_CREDITS);

endmodule : decode_stage

`default_nettype wire

// File: hdl/decode_top.sv
`default_nettype none

module decode_top
    import lc3b_types::*;
    import decode_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  lc3b_word         in_ir,
    input  lc3b_word         in_pc,
    output logic             in_credit,
    output logic             out_valid,
    output lc3b_control_word out_ctrl,
    output lc3b_word         out_sr1_data,
    output lc3b_word         out_sr2_data,
    output lc3b_word         out_ir,
    output lc3b_word         out_pc,
    input  logic             out_credit,
    input  logic             wb_valid,
    input  lc3b_reg          wb_dest,
    input  lc3b_word         wb_data
);

    credit_if #(.payload_t(fetch_bundle_t))   fetch_ch (.clk);
    credit_if #(.payload_t(decoded_bundle_t)) dec_ch   (.clk);

    assign fetch_ch.valid   = in_valid;
    assign fetch_ch.payload = '{ir: in_ir, pc: in_pc};
    assign in_credit        = fetch_ch.credit;

    assign out_valid     = dec_ch.valid;
    assign out_ctrl      = dec_ch.payload.ctrl;
    assign out_sr1_data  = dec_ch.payload.sr1_data;
    assign out_sr2_data  = dec_ch.payload.sr2_data;
    assign out_ir        = dec_ch.payload.ir;
    assign out_pc        = dec_ch.payload.pc;
    assign dec_ch.credit = out_credit; // consumer retired one bundle

    decode_stage u_decode (
        .clk, .rst_n,
        .fetch_ch (fetch_ch.receiver),
        .dec_ch   (dec_ch.sender),
        .wb_valid, .wb_dest, .wb_data
    );

endmodule : decode_top

`default_nettype wire

// File: tests/decode_vectors.svh
// columns: ir, pc_mux_sel, alu_op, alu_mux_sel, regfile_load, regfile_dest, then
// requires_sr1, requires_sr2 and data_memory_access packed as three flag bits
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

    task automatic load_vectors();
        vec.push_back({16'h6201, 2'd0, 3'd0, 3'd4, 1'b1, 3'd1, 3'b101}); // ldr r1, r0, #1
        vec.push_back({16'h2402, 2'd0, 3'd0, 3'd3, 1'b1, 3'd2, 3'b101}); // ldb r2, r0, #2
        vec.push_back({16'h1642, 2'd0, 3'd0, 3'd0, 1'b1, 3'd3, 3'b110}); // add r3, r1, r2
        vec.push_back({16'h18fd, 2'd0, 3'd0, 3'd1, 1'b1, 3'd4, 3'b100}); // add r4, r3, #-3
        vec.push_back({16'h5b01, 2'd0, 3'd1, 3'd0, 1'b1, 3'd5, 3'b110}); // and r5, r4, r1
        vec.push_back({16'h5d6f, 2'd0, 3'd1, 3'd1, 1'b1, 3'd6, 3'b100}); // and r6, r5, #15
        vec.push_back({16'h93bf, 2'd0, 3'd2, 3'd0, 1'b1, 3'd1, 3'b100}); // not r1, r6
        vec.push_back({16'hd443, 2'd0, 3'd4, 3'd2, 1'b1, 3'd2, 3'b100}); // lshf r2, r1, #3
        vec.push_back({16'hd691, 2'd0, 3'd5, 3'd2, 1'b1, 3'd3, 3'b100}); // rshfl r3, r2, #1
        vec.push_back({16'hd8f2, 2'd0, 3'd6, 3'd2, 1'b1, 3'd4, 3'b100}); // rshfa r4, r3, #2
        vec.push_back({16'h7880, 2'd0, 3'd0, 3'd4, 1'b0, 3'd0, 3'b111}); // str r4, r2, #0
        vec.push_back({16'h3645, 2'd0, 3'd0, 3'd3, 1'b0, 3'd0, 3'b111}); // stb r3, r1, #5
        vec.push_back({16'hb341, 2'd0, 3'd0, 3'd4, 1'b0, 3'd0, 3'b111}); // sti r1, r5, #1
        vec.push_back({16'hab02, 2'd0, 3'd0, 3'd4, 1'b1, 3'd5, 3'b101}); // ldi r5, r4, #2
        vec.push_back({16'hec04, 2'd0, 3'd3, 3'd0, 1'b1, 3'd6, 3'b000}); // lea r6, #4
        vec.push_back({16'h0ffe, 2'd1, 3'd3, 3'd0, 1'b0, 3'd0, 3'b000}); // brnzp #-2
        vec.push_back({16'hc180, 2'd2, 3'd3, 3'd0, 1'b0, 3'd0, 3'b100}); // jmp r6
        vec.push_back({16'h4840, 2'd1, 3'd3, 3'd0, 1'b1, 3'd7, 3'b100}); // jsr #0x40
        vec.push_back({16'h4140, 2'd2, 3'd3, 3'd0, 1'b1, 3'd7, 3'b100}); // jsrr r5
        vec.push_back({16'h8abc, 2'd0, 3'd0, 3'd0, 1'b0, 3'd0, 3'b000}); // rti slot, undecoded
        vec.push_back({16'hf025, 2'd3, 3'd3, 3'd0, 1'b1, 3'd7, 3'b001}); // trap x25
        vec.push_back({16'h1fc1, 2'd0, 3'd0, 3'd0, 1'b1, 3'd7, 3'b110}); // add r7, r7, r1
    endtask

`endif

// File: tests/tb_decode.sv
`default_nettype none

module tb_decode
    import lc3b_types::*;
    import decode_pkg::*;
();

    localparam int HOLD_CYCLES = 24; // out_credit withheld this long
    localparam int MAX_CYCLES  = 600;

    typedef struct packed {
        lc3b_word   ir;
        logic [1:0] pc_mux_sel;
        logic [2:0] alu_op;
        logic [2:0] alu_mux_sel;
        logic       regfile_load;
        lc3b_reg    regfile_dest;
        logic       requires_sr1;
        logic       requires_sr2;
        logic       data_memory_access;
    } vector_t;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    lc3b_word         in_ir;
    lc3b_word         in_pc;
    logic             in_credit;
    logic             out_valid;
    lc3b_control_word out_ctrl;
    lc3b_word         out_sr1_data;
    lc3b_word         out_sr2_data;
    lc3b_word         out_ir;
    lc3b_word         out_pc;
    logic             out_credit;
    logic             wb_valid;
    lc3b_reg          wb_dest;
    lc3b_word         wb_data;

    vector_t    vec [$];
    int         ret_q [$]; // emitted, not yet retired
    lc3b_word   shadow [8];
    logic [7:0] pend;      // loads seen but not written back
    int         sent;
    int         emitted;
    int         retired;
    int         credits_back;
    int         cyc;
    int         value_errs;
    int         other_errs;

    `include "decode_vectors.svh"

    decode_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n && in_credit) credits_back++;
    end

    function automatic lc3b_word pc_of(input int idx);
        return lc3b_word'(16'h3000 + 2 * idx);
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s bundle %0d: got 0x%0h expected 0x%0h", name, emitted, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_bundle();
        vector_t v;
        lc3b_reg s1;
        lc3b_reg s2;
        if (emitted >= vec.size()) begin
            $display("a bundle came out after the whole table was emitted");
            other_errs++;
            return;
        end
        v  = vec[emitted];
        s1 = v.ir[8:6];
        // stores read their data register from ir[11:9]
        s2 = (v.ir[13:12] == 2'b11 && v.ir[15:14] != 2'b11) ? v.ir[11:9] : v.ir[2:0];
        check_field("out_pc", out_pc, pc_of(emitted));
        check_field("out_ir", out_ir, v.ir);
        check_field("pc_mux_sel", out_ctrl.pc_mux_sel, v.pc_mux_sel);
        check_field("alu_op", out_ctrl.alu_op, v.alu_op);
        check_field("alu_mux_sel", out_ctrl.alu_mux_sel, v.alu_mux_sel);
        check_field("regfile_load", out_ctrl.regfile_load, v.regfile_load);
        check_field("regfile_dest", out_ctrl.regfile_dest, v.regfile_dest);
        check_field("requires_sr1", out_ctrl.requires_sr1, v.requires_sr1);
        check_field("requires_sr2", out_ctrl.requires_sr2, v.requires_sr2);
        check_field("data_memory_access", out_ctrl.data_memory_access, v.data_memory_access);
        if (v.ir[15:12] == 4'h8) check_field("out_ctrl", out_ctrl, 64'h0);
        if (v.requires_sr1) check_field("out_sr1_data", out_sr1_data, shadow[s1]);
        if (v.requires_sr2) check_field("out_sr2_data", out_sr2_data, shadow[s2]);
        if ((v.requires_sr1 && pend[s1]) || (v.requires_sr2 && pend[s2])) begin
            $display("bundle %0d was emitted while a source waited on writeback", emitted);
            other_errs++;
        end
        if (v.regfile_load) pend[v.regfile_dest] = 1'b1;
        ret_q.push_back(emitted);
        emitted++;
    endtask

    task automatic retire_bundle();
        vector_t v;
        v = vec[ret_q.pop_front()];
        out_credit = 1'b1;
        if (v.regfile_load) begin
            wb_valid = 1'b1;
            wb_dest  = v.regfile_dest;
            wb_data  = lc3b_word'($urandom);
            shadow[v.regfile_dest] = wb_data;
            pend[v.regfile_dest]   = 1'b0;
        end
        retired++;
    endtask

    task automatic check_hold();
        if (emitted > OUT_CREDITS) begin
            $display("%0d bundles came out while out_credit was withheld", emitted);
            other_errs++;
        end
        // one input credit per bundle that left the FIFO
        if (credits_back != emitted) begin
            $display("input credits did not stop with the FIFO full (%0d returned)", credits_back);
            other_errs++;
        end
    endtask

    initial begin
        void'($urandom(32'hc1e5420a));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_ir      = '0;
        in_pc      = '0;
        out_credit = 1'b0;
        wb_valid   = 1'b0;
        wb_dest    = '0;
        wb_data    = '0;
        pend       = '0;
        for (int i = 0; i < 8; i++) begin
            shadow[i] = '0;
        end
        load_vectors();
        repeat (8) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
                $display("out_valid or in_credit was high during reset");
                other_errs++;
            end
        end
        rst_n = 1'b1;
        cyc   = 0;
        while (retired < vec.size() && cyc < MAX_CYCLES) begin
            @(negedge clk);
            if (out_valid) check_bundle();
            out_credit = 1'b0;
            wb_valid   = 1'b0;
            if (cyc >= HOLD_CYCLES && ret_q.size() > 0 && ($urandom % 4) != 0) begin
                retire_bundle(); // random retire delay
            end
            if (sent < vec.size() && sent < IN_DEPTH + credits_back) begin
                in_valid = 1'b1;
                in_ir    = vec[sent].ir;
                in_pc    = pc_of(sent);
                sent++;
            end else begin
                in_valid = 1'b0;
            end
            if (cyc == HOLD_CYCLES - 1) check_hold();
            cyc++;
        end
        if (retired < vec.size()) begin
            $display("timeout: only %0d of %0d bundles retired", retired, vec.size());
            other_errs++;
        end
        if (credits_back != sent) begin
            $display("in_credit pulsed %0d times for %0d instructions sent", credits_back, sent);
            other_errs++;
        end
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_decode

`default_nettype wire

// File: build.f
+incdir+tests
common/lc3b_types.sv
common/decode_pkg.sv
common/credit_if.sv
decode/control_rom.sv
decode/regfile.sv
decode/scoreboard.sv
decode/decode_stage.sv
hdl/decode_top.sv
tests/tb_decode.sv
